// File: hw/cfg_bus_pkg.sv
/*
  Configuration bus widths and the access region code.
  Shared by the decode, the register file, the read mux and the top level.
*/

`default_nettype none

package cfg_bus_pkg;

  localparam int CFG_ADDR_W = 17;
  localparam int CFG_DATA_W = 32;
  localparam int CFG_BE_W   = CFG_DATA_W / 8;
  localparam int CHNL_ID_W  = 6;

  // Byte address, one word of data and its byte enables
  typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [CFG_DATA_W-1:0] cfg_data_t;
  typedef logic [CFG_BE_W-1:0]   cfg_be_t;

  // Channel id carried in the upper address bits
  typedef logic [CHNL_ID_W-1:0]  chnl_id_t;

  // Target that claims an access
  typedef enum logic [1:0] {
    REGION_NONE  = 2'd0,
    REGION_LOCAL = 2'd1,
    REGION_ADPT  = 2'd2
  } cfg_region_e;

endpackage

`default_nettype wire

// File: hw/csr_map_pkg.sv
/*
  Register map of the channel configuration space.
  Address field positions, the control byte type and the
  interface-control word layout.
*/

`default_nettype none

package csr_map_pkg;

  localparam int CSR_BYTE_W = 8;

  // One control byte as seen by the consumer
  typedef logic [CSR_BYTE_W-1:0] csr_byte_t;

  // Word index taken from address bits 9..2
  typedef logic [7:0] word_idx_t;

  //----------------------------------------------------------------------
  // Address fields
  //----------------------------------------------------------------------
  localparam int ADDR_ID_LSB     = 11;
  localparam int ADDR_ID_MSB     = 16;
  // 0 selects the local registers, 1 the adapter
  localparam int ADDR_REGION_BIT = 10;
  localparam int WORD_IDX_LSB    = 2;

  //----------------------------------------------------------------------
  // Interface-control word
  //----------------------------------------------------------------------
  localparam int IFCTL_USR_ACTIVE_BIT = 0;

endpackage

`default_nettype wire

// File: hw/cfg_addr_decode.sv
/*
  Address decode of the configuration bus.
  Matches the channel id, picks the local or adapter region and issues
  the strobes of the chosen target. Purely combinational.
*/

`timescale 1ns/1ps
`default_nettype none

module cfg_addr_decode #(
  parameter int N_CSR_WORDS = 8
) (
  input  wire                      i_cfg_avmm_write,
  input  wire                      i_cfg_avmm_read,
  input  wire cfg_bus_pkg::cfg_addr_t  i_cfg_avmm_addr,
  input  wire cfg_bus_pkg::chnl_id_t   i_cfg_avmm_addr_id,
  input  wire                      i_usr_active,

  output cfg_bus_pkg::cfg_region_e o_region,
  output logic                     o_local_wr,
  output logic                     o_local_rd,
  output csr_map_pkg::word_idx_t   o_word_idx,
  output logic                     o_adpt_wr,
  output logic                     o_adpt_rd
);

  logic id_match;
  logic adpt_sel;
  logic idx_in_range;

  assign id_match = (i_cfg_avmm_addr[csr_map_pkg::ADDR_ID_MSB:csr_map_pkg::ADDR_ID_LSB]
                     == i_cfg_avmm_addr_id);
  assign adpt_sel = i_cfg_avmm_addr[csr_map_pkg::ADDR_REGION_BIT];

  assign o_word_idx = i_cfg_avmm_addr[csr_map_pkg::WORD_IDX_LSB +:
                                      $bits(csr_map_pkg::word_idx_t)];

  // Control words plus the interface-control word
  assign idx_in_range = (o_word_idx <= csr_map_pkg::word_idx_t'(N_CSR_WORDS));

  // Adapter is only reachable once the user side is active
  always_comb begin
    if (!id_match) begin
      o_region = cfg_bus_pkg::REGION_NONE;
    end else if (!adpt_sel) begin
      o_region = cfg_bus_pkg::REGION_LOCAL;
    end else if (i_usr_active) begin
      o_region = cfg_bus_pkg::REGION_ADPT;
    end else begin
      o_region = cfg_bus_pkg::REGION_NONE;
    end
  end

  // Writes above the interface-control word are dropped here
  assign o_local_wr = i_cfg_avmm_write && (o_region == cfg_bus_pkg::REGION_LOCAL)
                      && idx_in_range;
  assign o_local_rd = i_cfg_avmm_read && (o_region == cfg_bus_pkg::REGION_LOCAL);

  assign o_adpt_wr = i_cfg_avmm_write && (o_region == cfg_bus_pkg::REGION_ADPT);
  assign o_adpt_rd = i_cfg_avmm_read && (o_region == cfg_bus_pkg::REGION_ADPT);

endmodule

`default_nettype wire

// File: hw/csr_regfile.sv
/*
  Local channel control registers with byte-enable writes.
  Word N_CSR_WORDS is the interface-control word, higher indices read zero.
  Reads return data and a valid pulse one cycle after the strobe.
*/

`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
  parameter int N_CSR_WORDS = 8
) (
  input  wire                          i_cfg_avmm_clk,
  input  wire                          i_rst_n,
  input  wire                          i_local_wr,
  input  wire                          i_local_rd,
  input  wire csr_map_pkg::word_idx_t  i_word_idx,
  input  wire cfg_bus_pkg::cfg_data_t  i_wdata,
  input  wire cfg_bus_pkg::cfg_be_t    i_byte_en,

  output cfg_bus_pkg::cfg_data_t                       o_rdata,
  output logic                                         o_rdatavld,
  output csr_map_pkg::csr_byte_t [N_CSR_WORDS*4-1:0]   o_csr_ctrl,
  output logic                                         o_usr_active
);

  localparam int N_BYTES = $bits(cfg_bus_pkg::cfg_be_t);
  localparam int BYTE_W  = $bits(csr_map_pkg::csr_byte_t);

  // Byte w*4+b is byte b of control word w
  csr_map_pkg::csr_byte_t [N_CSR_WORDS*N_BYTES-1:0] ctrl_q;
  cfg_bus_pkg::cfg_data_t                           ifctl_q;
  cfg_bus_pkg::cfg_data_t                           rd_word;
  logic                                             ifctl_sel;

  assign ifctl_sel = (i_word_idx == csr_map_pkg::word_idx_t'(N_CSR_WORDS));

  //----------------------------------------------------------------------
  // Write path
  //----------------------------------------------------------------------
  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else if (i_local_wr) begin
      for (int w = 0; w < N_CSR_WORDS; w++) begin
        for (int b = 0; b < N_BYTES; b++) begin
          if ((i_word_idx == csr_map_pkg::word_idx_t'(w)) && i_byte_en[b]) begin
            ctrl_q[w*N_BYTES+b] <= i_wdata[b*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ifctl_q <= '0;
    end else if (i_local_wr && ifctl_sel) begin
      for (int b = 0; b < N_BYTES; b++) begin
        if (i_byte_en[b]) begin
          ifctl_q[b*BYTE_W +: BYTE_W] <= i_wdata[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  //----------------------------------------------------------------------
  // Read path
  //----------------------------------------------------------------------
  always_comb begin
    rd_word = '0;
    for (int w = 0; w < N_CSR_WORDS; w++) begin
      if (i_word_idx == csr_map_pkg::word_idx_t'(w)) begin
        rd_word = ctrl_q[w*N_BYTES +: N_BYTES];
      end
    end
    if (ifctl_sel) begin
      rd_word = ifctl_q;
    end
  end

  // Read data held until the next local read
  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdata <= '0;
    end else if (i_local_rd) begin
      o_rdata <= rd_word;
    end
  end

  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rdatavld <= 1'b0;
    end else begin
      o_rdatavld <= i_local_rd;
    end
  end

  assign o_csr_ctrl   = ctrl_q;
  assign o_usr_active = ifctl_q[csr_map_pkg::IFCTL_USR_ACTIVE_BIT];

endmodule

`default_nettype wire

// File: hw/cfg_rdata_mux.sv
/*
  Response merge for the configuration bus.
  Combines local and adapter read data, answers unclaimed reads with zero
  one cycle later and forwards adapter wait request.
*/

`timescale 1ns/1ps
`default_nettype none

module cfg_rdata_mux (
  input  wire                            i_cfg_avmm_clk,
  input  wire                            i_rst_n,
  input  wire cfg_bus_pkg::cfg_region_e  i_region,
  input  wire                            i_cfg_avmm_read,

  input  wire cfg_bus_pkg::cfg_data_t    i_local_rdata,
  input  wire                            i_local_rdatavld,

  input  wire cfg_bus_pkg::cfg_data_t    i_adpt_rdata,
  input  wire                            i_adpt_rdatavld,
  input  wire                            i_adpt_waitreq,

  output cfg_bus_pkg::cfg_data_t         o_rdata,
  output logic                           o_rdatavld,
  output logic                           o_waitreq
);

  logic null_rd_q;

  // Unclaimed read still needs a valid pulse
  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      null_rd_q <= 1'b0;
    end else begin
      null_rd_q <= i_cfg_avmm_read && (i_region == cfg_bus_pkg::REGION_NONE);
    end
  end

  assign o_rdatavld = i_local_rdatavld | i_adpt_rdatavld | null_rd_q;

  always_comb begin
    if (i_local_rdatavld) begin
      o_rdata = i_local_rdata;
    end else if (i_adpt_rdatavld) begin
      o_rdata = i_adpt_rdata;
    end else begin
      o_rdata = '0;
    end
  end

  // Local and unclaimed accesses never stall
  assign o_waitreq = (i_region == cfg_bus_pkg::REGION_ADPT) ? i_adpt_waitreq : 1'b0;

endmodule

`default_nettype wire

// File: hw/hard_rst_ctrl.sv
/*
  Hard-reset release for the channel.
  Waits for CSR ready and user mode, then releases o_hard_rst_n through
  a two-flop synchronizer in the configuration clock domain.
*/

`timescale 1ns/1ps
`default_nettype none

module hard_rst_ctrl (
  input  wire   i_cfg_avmm_clk,
  input  wire   i_rst_n,
  input  wire   i_csr_rdy_dly_in,
  input  wire   i_usermode_in,
  output logic  o_hard_rst_n
);

  logic       rst_release;
  logic [1:0] sync_q;

  // Both inputs may come from other domains
  assign rst_release = i_csr_rdy_dly_in & i_usermode_in;

  always_ff @(posedge i_cfg_avmm_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], rst_release};
    end
  end

  assign o_hard_rst_n = sync_q[1];

endmodule

`default_nettype wire

// File: hw/chnl_cfg_top.sv
/*
  Configuration front end of one adapter channel.
  Connects address decode, local register file, read-data mux and the
  hard-reset controller. Adapter accesses share the external bus address
  and data and get only their own strobes.
*/

`timescale 1ns/1ps
`default_nettype none

module chnl_cfg_top #(
  parameter int N_CSR_WORDS = 8
) (
  input  wire                           i_cfg_avmm_clk,
  input  wire                           i_rst_n,

  // Configuration bus slave
  input  wire                           i_cfg_avmm_write,
  input  wire                           i_cfg_avmm_read,
  input  wire cfg_bus_pkg::cfg_addr_t   i_cfg_avmm_addr,
  input  wire cfg_bus_pkg::cfg_data_t   i_cfg_avmm_wdata,
  input  wire cfg_bus_pkg::cfg_be_t     i_cfg_avmm_byte_en,
  input  wire cfg_bus_pkg::chnl_id_t    i_cfg_avmm_addr_id,
  output cfg_bus_pkg::cfg_data_t        o_cfg_avmm_rdata,
  output logic                          o_cfg_avmm_rdatavld,
  output logic                          o_cfg_avmm_waitreq,

  // Adapter target
  output logic                          o_adpt_cfg_write,
  output logic                          o_adpt_cfg_read,
  input  wire cfg_bus_pkg::cfg_data_t   i_adpt_cfg_rdata,
  input  wire                           i_adpt_cfg_rdatavld,
  input  wire                           i_adpt_cfg_waitreq,

  // Hard reset
  input  wire                           i_csr_rdy_dly_in,
  input  wire                           i_usermode_in,

  output csr_map_pkg::csr_byte_t [N_CSR_WORDS*4-1:0] o_csr_ctrl,
  output logic                          o_usr_active,
  output logic                          o_hard_rst_n
);

  cfg_bus_pkg::cfg_region_e region;
  csr_map_pkg::word_idx_t   word_idx;
  cfg_bus_pkg::cfg_data_t   local_rdata;
  logic                     local_wr;
  logic                     local_rd;
  logic                     local_rdatavld;

  //----------------------------------------------------------------------
  // Decode
  //----------------------------------------------------------------------
  cfg_addr_decode #(
    .N_CSR_WORDS (N_CSR_WORDS)
  ) u_addr_decode (
    .i_cfg_avmm_write   (i_cfg_avmm_write),
    .i_cfg_avmm_read    (i_cfg_avmm_read),
    .i_cfg_avmm_addr    (i_cfg_avmm_addr),
    .i_cfg_avmm_addr_id (i_cfg_avmm_addr_id),
    .i_usr_active       (o_usr_active),
    .o_region           (region),
    .o_local_wr         (local_wr),
    .o_local_rd         (local_rd),
    .o_word_idx         (word_idx),
    .o_adpt_wr          (o_adpt_cfg_write),
    .o_adpt_rd          (o_adpt_cfg_read)
  );

  //----------------------------------------------------------------------
  // Local registers
  //----------------------------------------------------------------------
  csr_regfile #(
    .N_CSR_WORDS (N_CSR_WORDS)
  ) u_csr_regfile (
    .i_cfg_avmm_clk (i_cfg_avmm_clk),
    .i_rst_n        (i_rst_n),
    .i_local_wr     (local_wr),
    .i_local_rd     (local_rd),
    .i_word_idx     (word_idx),
    .i_wdata        (i_cfg_avmm_wdata),
    .i_byte_en      (i_cfg_avmm_byte_en),
    .o_rdata        (local_rdata),
    .o_rdatavld     (local_rdatavld),
    .o_csr_ctrl     (o_csr_ctrl),
    .o_usr_active   (o_usr_active)
  );

  //----------------------------------------------------------------------
  // Response merge
  //----------------------------------------------------------------------
  cfg_rdata_mux u_rdata_mux (
    .i_cfg_avmm_clk   (i_cfg_avmm_clk),
    .i_rst_n          (i_rst_n),
    .i_region         (region),
    .i_cfg_avmm_read  (i_cfg_avmm_read),
    .i_local_rdata    (local_rdata),
    .i_local_rdatavld (local_rdatavld),
    .i_adpt_rdata     (i_adpt_cfg_rdata),
    .i_adpt_rdatavld  (i_adpt_cfg_rdatavld),
    .i_adpt_waitreq   (i_adpt_cfg_waitreq),
    .o_rdata          (o_cfg_avmm_rdata),
    .o_rdatavld       (o_cfg_avmm_rdatavld),
    .o_waitreq        (o_cfg_avmm_waitreq)
  );

  // Hard reset release
  hard_rst_ctrl u_hard_rst_ctrl (
    .i_cfg_avmm_clk   (i_cfg_avmm_clk),
    .i_rst_n          (i_rst_n),
    .i_csr_rdy_dly_in (i_csr_rdy_dly_in),
    .i_usermode_in    (i_usermode_in),
    .o_hard_rst_n     (o_hard_rst_n)
  );

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
/*
  Clock and reset source of the testbench.
  Free-running clock and a reset held low for the first two cycles.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  // Released just after the second rising edge
  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    #0.5;
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_chnl_cfg.sv
/*
  Directed testbench of the channel configuration front end.
  Drives the configuration bus, models the adapter target and checks
  every response against a register mirror.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_chnl_cfg;

  localparam int  N_CSR_WORDS = 8;
  localparam int  N_TESTS     = 6;
  localparam int  WDOG_CYCLES = N_TESTS * 200;
  localparam real DRIVE_DLY   = 0.5;
  localparam cfg_bus_pkg::chnl_id_t CHNL_ID  = 6'h2b;
  localparam cfg_bus_pkg::chnl_id_t WRONG_ID = 6'h14;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       avmm_write;
  logic                                       avmm_read;
  cfg_bus_pkg::cfg_addr_t                     avmm_addr;
  cfg_bus_pkg::cfg_data_t                     avmm_wdata;
  cfg_bus_pkg::cfg_be_t                       avmm_byte_en;
  cfg_bus_pkg::cfg_data_t                     avmm_rdata;
  logic                                       avmm_rdatavld;
  logic                                       avmm_waitreq;
  logic                                       adpt_write;
  logic                                       adpt_read;
  cfg_bus_pkg::cfg_data_t                     adpt_rdata;
  logic                                       adpt_rdatavld;
  logic                                       adpt_waitreq;
  logic                                       csr_rdy;
  logic                                       usermode;
  csr_map_pkg::csr_byte_t [N_CSR_WORDS*4-1:0] csr_ctrl;
  logic                                       usr_active;
  logic                                       hard_rst_n;

  // Last entry mirrors the interface-control word
  cfg_bus_pkg::cfg_data_t mirror [0:N_CSR_WORDS];
  logic [31:0]            lcg_state = 32'ha587d130;
  int                     errors = 0;
  int                     adpt_accesses = 0;

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  chnl_cfg_top #(
    .N_CSR_WORDS (N_CSR_WORDS)
  ) u_dut (
    .i_cfg_avmm_clk      (clk),
    .i_rst_n             (rst_n),
    .i_cfg_avmm_write    (avmm_write),
    .i_cfg_avmm_read     (avmm_read),
    .i_cfg_avmm_addr     (avmm_addr),
    .i_cfg_avmm_wdata    (avmm_wdata),
    .i_cfg_avmm_byte_en  (avmm_byte_en),
    .i_cfg_avmm_addr_id  (CHNL_ID),
    .o_cfg_avmm_rdata    (avmm_rdata),
    .o_cfg_avmm_rdatavld (avmm_rdatavld),
    .o_cfg_avmm_waitreq  (avmm_waitreq),
    .o_adpt_cfg_write    (adpt_write),
    .o_adpt_cfg_read     (adpt_read),
    .i_adpt_cfg_rdata    (adpt_rdata),
    .i_adpt_cfg_rdatavld (adpt_rdatavld),
    .i_adpt_cfg_waitreq  (adpt_waitreq),
    .i_csr_rdy_dly_in    (csr_rdy),
    .i_usermode_in       (usermode),
    .o_csr_ctrl          (csr_ctrl),
    .o_usr_active        (usr_active),
    .o_hard_rst_n        (hard_rst_n)
  );

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Channel id, region bit, word index, byte offset
  function automatic cfg_bus_pkg::cfg_addr_t make_addr(cfg_bus_pkg::chnl_id_t id,
                                                        logic adpt, int idx);
    return {id, adpt, idx[7:0], 2'b00};
  endfunction

  function automatic cfg_bus_pkg::cfg_data_t adpt_pattern(cfg_bus_pkg::cfg_addr_t addr);
    return {7'h5a, addr, 8'hc3};
  endfunction

  function automatic cfg_bus_pkg::cfg_data_t merge_bytes(cfg_bus_pkg::cfg_data_t old,
                                                          cfg_bus_pkg::cfg_data_t wdata,
                                                          cfg_bus_pkg::cfg_be_t be);
    cfg_bus_pkg::cfg_data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic tick();
    @(posedge clk);
    #(DRIVE_DLY);
  endtask

  task automatic check_data(input string name, input cfg_bus_pkg::cfg_data_t got,
                            input cfg_bus_pkg::cfg_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_ctrl_vector();
    for (int w = 0; w < N_CSR_WORDS; w++) begin
      check_data($sformatf("o_csr_ctrl word %0d", w), csr_ctrl[w*4 +: 4], mirror[w]);
    end
  endtask

  //----------------------------------------------------------------------
  // Bus master
  //----------------------------------------------------------------------
  task automatic bus_write(input cfg_bus_pkg::cfg_addr_t addr,
                           input cfg_bus_pkg::cfg_data_t data, input cfg_bus_pkg::cfg_be_t be);
    tick();
    avmm_write   = 1'b1;
    avmm_addr    = addr;
    avmm_wdata   = data;
    avmm_byte_en = be;
    @(negedge clk);
    while (avmm_waitreq) @(negedge clk);
    tick();
    avmm_write = 1'b0;
  endtask

  // Completes the read, then counts cycles until read valid
  task automatic read_and_check(input cfg_bus_pkg::cfg_addr_t addr,
                                input cfg_bus_pkg::cfg_data_t exp, input bit exact_lat);
    int lat;
    tick();
    avmm_read = 1'b1;
    avmm_addr = addr;
    @(negedge clk);
    while (avmm_waitreq) @(negedge clk);
    tick();
    avmm_read = 1'b0;
    lat = 1;
    @(negedge clk);
    while (!avmm_rdatavld && lat < 8) begin
      lat++;
      @(negedge clk);
    end
    if (!avmm_rdatavld) begin
      errors++;
      $display("Read of address 0x%05h never returned read valid", addr);
    end else begin
      check_data("o_cfg_avmm_rdata", avmm_rdata, exp);
      if (exact_lat && lat != 1) begin
        errors++;
        $display("Read valid came %0d cycles after the read instead of one", lat);
      end
    end
  endtask

  //----------------------------------------------------------------------
  // Adapter target model
  //----------------------------------------------------------------------
  initial begin
    logic                   is_rd;
    cfg_bus_pkg::cfg_data_t pattern;
    int                     n_wait;
    adpt_waitreq  = 1'b1;
    adpt_rdatavld = 1'b0;
    adpt_rdata    = '0;
    forever begin
      @(negedge clk);
      if (adpt_read || adpt_write) begin
        adpt_accesses++;
        is_rd   = adpt_read;
        pattern = adpt_pattern(avmm_addr);
        n_wait  = 1 + int'(lcg_next() % 3);
        for (int i = 1; i < n_wait; i++) begin
          @(negedge clk);
          if (!(adpt_read || adpt_write)) begin
            errors++;
            $display("Adapter strobe dropped while wait request was high");
          end
        end
        tick();
        adpt_waitreq = 1'b0;
        tick();
        adpt_waitreq = 1'b1;
        if (is_rd) begin
          adpt_rdatavld = 1'b1;
          adpt_rdata    = pattern;
          tick();
          adpt_rdatavld = 1'b0;
          adpt_rdata    = '0;
        end
      end
    end
  end

  //----------------------------------------------------------------------
  // Tests
  //----------------------------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk);
    check_bit("o_cfg_avmm_rdatavld", avmm_rdatavld, 1'b0);
    check_bit("o_cfg_avmm_waitreq", avmm_waitreq, 1'b0);
    check_bit("o_adpt_cfg_write", adpt_write, 1'b0);
    check_bit("o_adpt_cfg_read", adpt_read, 1'b0);
    check_bit("o_usr_active", usr_active, 1'b0);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b0);
    check_ctrl_vector();
    for (int w = 0; w < N_CSR_WORDS + 3; w++) begin
      read_and_check(make_addr(CHNL_ID, 1'b0, w), '0, 1'b1);
    end
  endtask

  task automatic test_byte_enable_writes();
    cfg_bus_pkg::cfg_data_t data;
    logic [31:0]            r;
    for (int pass = 0; pass < 2; pass++) begin
      for (int w = 0; w <= N_CSR_WORDS; w++) begin
        data = lcg_next();
        r    = lcg_next();
        bus_write(make_addr(CHNL_ID, 1'b0, w), data, r[3:0]);
        mirror[w] = merge_bytes(mirror[w], data, r[3:0]);
      end
    end
    for (int w = 0; w <= N_CSR_WORDS; w++) begin
      read_and_check(make_addr(CHNL_ID, 1'b0, w), mirror[w], 1'b1);
    end
    check_ctrl_vector();
    check_bit("o_usr_active", usr_active, mirror[N_CSR_WORDS][0]);
    // Beyond the interface-control word
    for (int w = N_CSR_WORDS + 1; w < N_CSR_WORDS + 4; w++) begin
      bus_write(make_addr(CHNL_ID, 1'b0, w), lcg_next(), 4'hf);
      read_and_check(make_addr(CHNL_ID, 1'b0, w), '0, 1'b1);
    end
    check_ctrl_vector();
    read_and_check(make_addr(CHNL_ID, 1'b0, N_CSR_WORDS), mirror[N_CSR_WORDS], 1'b1);
  endtask

  task automatic test_chnl_id_mismatch();
    for (int w = 0; w <= N_CSR_WORDS; w++) begin
      bus_write(make_addr(WRONG_ID, 1'b0, w), lcg_next(), 4'hf);
    end
    check_ctrl_vector();
    check_bit("o_usr_active", usr_active, mirror[N_CSR_WORDS][0]);
    for (int w = 0; w <= N_CSR_WORDS; w++) begin
      read_and_check(make_addr(WRONG_ID, 1'b0, w), '0, 1'b1);
    end
    read_and_check(make_addr(CHNL_ID, 1'b0, N_CSR_WORDS), mirror[N_CSR_WORDS], 1'b1);
  endtask

  task automatic test_adpt_gating();
    cfg_bus_pkg::cfg_addr_t addr;
    logic [31:0]            r;
    bus_write(make_addr(CHNL_ID, 1'b0, N_CSR_WORDS), '0, 4'hf);
    mirror[N_CSR_WORDS] = '0;
    check_bit("o_usr_active", usr_active, 1'b0);
    adpt_accesses = 0;
    bus_write(make_addr(CHNL_ID, 1'b1, 3), lcg_next(), 4'hf);
    read_and_check(make_addr(CHNL_ID, 1'b1, 3), '0, 1'b1);
    if (adpt_accesses != 0) begin
      errors++;
      $display("Adapter strobe raised while user-active was clear");
    end
    bus_write(make_addr(CHNL_ID, 1'b0, N_CSR_WORDS), 32'h1, 4'h1);
    mirror[N_CSR_WORDS] = merge_bytes(mirror[N_CSR_WORDS], 32'h1, 4'h1);
    check_bit("o_usr_active", usr_active, 1'b1);
    for (int k = 0; k < 4; k++) begin
      r    = lcg_next();
      addr = make_addr(CHNL_ID, 1'b1, int'(r[7:0]));
      bus_write(addr, lcg_next(), 4'hf);
      read_and_check(addr, adpt_pattern(addr), 1'b0);
    end
    if (adpt_accesses != 8) begin
      errors++;
      $display("Expected 8 forwarded adapter accesses but saw %0d", adpt_accesses);
    end
    check_ctrl_vector();
  endtask

  task automatic test_back_to_back_reads();
    tick();
    avmm_read = 1'b1;
    avmm_addr = make_addr(CHNL_ID, 1'b0, 0);
    for (int w = 1; w <= N_CSR_WORDS; w++) begin
      tick();
      avmm_addr = make_addr(CHNL_ID, 1'b0, w);
      @(negedge clk);
      check_bit("o_cfg_avmm_rdatavld", avmm_rdatavld, 1'b1);
      check_data("o_cfg_avmm_rdata", avmm_rdata, mirror[w-1]);
    end
    tick();
    avmm_read = 1'b0;
    @(negedge clk);
    check_bit("o_cfg_avmm_rdatavld", avmm_rdatavld, 1'b1);
    check_data("o_cfg_avmm_rdata", avmm_rdata, mirror[N_CSR_WORDS]);
    tick();
    @(negedge clk);
    check_bit("o_cfg_avmm_rdatavld", avmm_rdatavld, 1'b0);
  endtask

  task automatic test_hard_rst_release();
    tick();
    csr_rdy = 1'b1;
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b0);
    tick();
    usermode = 1'b1;
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b0);
    tick();
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b0);
    tick();
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b1);
    tick();
    usermode = 1'b0;
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b1);
    tick();
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b1);
    tick();
    @(negedge clk);
    check_bit("o_hard_rst_n", hard_rst_n, 1'b0);
  endtask

  //----------------------------------------------------------------------
  // Sequence and watchdog
  //----------------------------------------------------------------------
  initial begin
    avmm_write   = 1'b0;
    avmm_read    = 1'b0;
    avmm_addr    = '0;
    avmm_wdata   = '0;
    avmm_byte_en = '0;
    csr_rdy      = 1'b0;
    usermode     = 1'b0;
    foreach (mirror[w]) mirror[w] = '0;
    wait (rst_n === 1'b1);
    test_reset_state();
    test_byte_enable_writes();
    test_chnl_id_mismatch();
    test_adpt_gating();
    test_back_to_back_reads();
    test_hard_rst_release();
    $display("Run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WDOG_CYCLES);
    $display("Run stopped, %0d errors", errors);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hw/cfg_bus_pkg.sv
hw/csr_map_pkg.sv
hw/cfg_addr_decode.sv
hw/csr_regfile.sv
hw/cfg_rdata_mux.sv
hw/hard_rst_ctrl.sv
hw/chnl_cfg_top.sv
test/tb_clk_gen.sv
test/tb_chnl_cfg.sv

// File: Bender.yml
package:
  name: chnl_cfg

sources:
  - files:
      - hw/cfg_bus_pkg.sv
      - hw/csr_map_pkg.sv
      - hw/cfg_addr_decode.sv
      - hw/csr_regfile.sv
      - hw/cfg_rdata_mux.sv
      - hw/hard_rst_ctrl.sv
      - hw/chnl_cfg_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_chnl_cfg.sv
